/* Bender.yml */
package:
  name: wave_disp

export_include_dirs:
  - .

sources:
  - wave_disp_pkg.sv
  - wave_ram.sv
  - vga_ctrl.sv
  - vga_pic.sv
  - hdmi_top.sv
  - target: test
    files:
      - tb_hdmi_top.sv

/* hdmi_top.sv */
`timescale 1ns/100ps

module hdmi_top (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  wave_disp_pkg::apb_req_t      apb_req,
    output wave_disp_pkg::apb_rsp_t      apb_rsp,
    output logic                         pixclk_out,
    output logic                         vs_out,
    output logic                         hs_out,
    output logic                         de_out,
    output logic [7:0]                   r_out,
    output logic [7:0]                   g_out,
    output logic [7:0]                   b_out
);

    wave_disp_pkg::pix_coord_t  pix_x;
    wave_disp_pkg::pix_coord_t  pix_y;
    wave_disp_pkg::rgb565_t     pix_data;
    wave_disp_pkg::rgb565_t     rgb565;
    wave_disp_pkg::video_sync_t sync;
    wave_disp_pkg::wave_addr_t  wave_rd_addr;
    wave_disp_pkg::sample_t     wave_rd_data;
    logic                       ram_rd_en;
    logic                       ram_rd_over;

    // sample store, host on apb, display on the read port
    wave_ram u_wave_ram (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .ram_rd_en    (ram_rd_en),
        .wave_rd_addr (wave_rd_addr),
        .ram_rd_over  (ram_rd_over),
        .wave_rd_data (wave_rd_data)
    );

    // raster timing
    vga_ctrl u_vga_ctrl (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .pix_data     (pix_data),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .sync         (sync),
        .ram_rd_en    (ram_rd_en),
        .wave_rd_addr (wave_rd_addr),
        .ram_rd_over  (ram_rd_over),
        .rgb          (rgb565)
    );

    // trace and graticule
    vga_pic u_vga_pic (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .wave_rd_data (wave_rd_data),
        .pix_data     (pix_data)
    );

    //////////////////////////////////////////////////////////////////////
    // transmitter port
    //////////////////////////////////////////////////////////////////////

    // pixel clock is the system clock
    assign pixclk_out = sys_clk;
    assign hs_out     = sync.hs;
    assign vs_out     = sync.vs;
    assign de_out     = sync.de;

    // rgb565 to rgb888, fields msb aligned
    assign r_out = {rgb565[15:11], 3'b000};
    assign g_out = {rgb565[10:5], 2'b00};
    assign b_out = {rgb565[4:0], 3'b000};

endmodule

/* tb.f */
+incdir+.
wave_disp_pkg.sv
wave_ram.sv
vga_ctrl.sv
vga_pic.sv
hdmi_top.sv
tb_hdmi_top.sv

/* tb_hdmi_top.sv */
`timescale 1ns/100ps
`include "wave_disp_defs.svh"

module tb_hdmi_top;

    localparam int FRAME_CYCLES    = `H_TOTAL * `V_TOTAL;
    // tests 1, 2, 4 and 5 watch the raster
    localparam int DISPLAY_TESTS   = 4;
    // test 3 makes 102 accesses, tests 4 and 5 make 303 each
    localparam int APB_ACCESSES    = 102 + 303 + 303;
    localparam int WATCHDOG_CYCLES =
        (DISPLAY_TESTS * 4 * FRAME_CYCLES + APB_ACCESSES * 20) * 11 / 10;

    logic                    sys_clk;
    logic                    rst_n;
    wave_disp_pkg::apb_req_t apb_req;
    wave_disp_pkg::apb_rsp_t apb_rsp;
    logic                    pixclk_out;
    logic                    vs_out;
    logic                    hs_out;
    logic                    de_out;
    logic [7:0]              r_out;
    logic [7:0]              g_out;
    logic [7:0]              b_out;

    // model of both banks, model_bank is the one on screen
    wave_disp_pkg::sample_t  model_mem [0:1][0:`H_ACTIVE-1];
    logic                    model_bank;
    logic                    model_pending;
    // raster position rebuilt from de and vs
    int                      col_cnt;
    int                      row_cnt;
    int                      hs_len;
    int                      vs_len;
    int                      line_len;
    logic                    hs_q;
    logic                    de_q;
    logic [23:0]             exp_rgb;
    int                      errors;
    int                      tests_failed;
    integer                  seed;

    hdmi_top u_hdmi_top (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .pixclk_out (pixclk_out),
        .vs_out     (vs_out),
        .hs_out     (hs_out),
        .de_out     (de_out),
        .r_out      (r_out),
        .g_out      (g_out),
        .b_out      (b_out)
    );

    // 100 ns pixel clock
    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    always @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt       <= 0;
            row_cnt       <= 0;
            hs_len        <= 0;
            vs_len        <= 0;
            line_len      <= 0;
            hs_q          <= 1'b0;
            de_q          <= 1'b0;
            model_bank    <= 1'b0;
            model_pending <= 1'b0;
        end else begin
            hs_q   <= hs_out;
            de_q   <= de_out;
            hs_len <= hs_out ? hs_len + 1 : 0;
            vs_len <= vs_out ? vs_len + 1 : 0;
            // clocks since the last hs rise, 0 until the first one
            if (hs_out && !hs_q)
                line_len <= 1;
            else if (line_len != 0)
                line_len <= line_len + 1;
            if (vs_out) begin
                col_cnt <= 0;
                row_cnt <= 0;
            end else if (de_out) begin
                col_cnt <= col_cnt + 1;
            end else if (de_q) begin
                col_cnt <= 0;
                row_cnt <= row_cnt + 1;
                // end of the 256th run closes the frame
                if (row_cnt == `V_ACTIVE - 1 && model_pending) begin
                    model_bank    <= ~model_bank;
                    model_pending <= 1'b0;
                end
            end
        end
    end

    // trace over grid over background, fields msb aligned
    function automatic logic [23:0] expected_pixel(input int col, input int row,
                                                   input wave_disp_pkg::sample_t s);
        logic [15:0] c;
        if (row + s == 255)
            c = `COL_TRACE;
        else if ((col % `GRID_X) == 0 || (row % `GRID_Y) == 0)
            c = `COL_GRID;
        else
            c = `COL_BG;
        return {c[15:11], 3'b000, c[10:5], 2'b00, c[4:0], 3'b000};
    endfunction

    always_comb begin
        exp_rgb = expected_pixel(col_cnt, row_cnt,
                                 model_mem[model_bank][col_cnt % `H_ACTIVE]);
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    a_line_period: assert property (@(posedge sys_clk) disable iff (!rst_n)
        ($rose(hs_out) && line_len != 0) |-> (line_len == `H_TOTAL))
        else fail_value("hs_out period", $sampled(line_len), `H_TOTAL);

    a_hs_width: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $fell(hs_out) |-> (hs_len == `H_SYNC))
        else fail_value("hs_out width", $sampled(hs_len), `H_SYNC);

    a_de_run: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $fell(de_out) |-> (col_cnt == `H_ACTIVE))
        else fail_value("de_out run", $sampled(col_cnt), `H_ACTIVE);

    a_frame_runs: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(vs_out) |-> (row_cnt == `V_ACTIVE))
        else fail_value("de_out runs per frame", $sampled(row_cnt), `V_ACTIVE);

    a_vs_width: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $fell(vs_out) |-> (vs_len == `V_SYNC * `H_TOTAL))
        else fail_value("vs_out width", $sampled(vs_len), `V_SYNC * `H_TOTAL);

    // expected low bits are zero, so this covers the expansion too
    a_pixel: assert property (@(posedge sys_clk) disable iff (!rst_n)
        de_out |-> ({r_out, g_out, b_out} == exp_rgb))
        else fail_value("rgb_out", $sampled({r_out, g_out, b_out}), $sampled(exp_rgb));

    a_pready: assert property (@(posedge sys_clk) disable iff (!rst_n)
        apb_rsp.pready)
        else fail_value("pready", 0, 1);

    // pixel clock output follows sys_clk on both edges
    always @(sys_clk) begin
        #1;
        assert (pixclk_out === sys_clk)
            else fail_value("pixclk_out", pixclk_out, sys_clk);
    end

    //////////////////////////////////////////////////////////////////////
    // apb host
    //////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input wave_disp_pkg::apb_addr_t addr,
                              input wave_disp_pkg::apb_data_t wdata,
                              output wave_disp_pkg::apb_data_t rdata, output logic err);
        @(posedge sys_clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge sys_clk);
        apb_req.penable <= 1'b1;
        // response settles mid access cycle
        @(negedge sys_clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge sys_clk);
        apb_req <= '0;
    endtask

    task automatic write_word(input wave_disp_pkg::apb_addr_t addr,
                              input wave_disp_pkg::apb_data_t d, input logic exp_err);
        wave_disp_pkg::apb_data_t rd;
        logic                     e;
        apb_access(1'b1, addr, d, rd, e);
        if (e !== exp_err)
            fail_value("pslverr", e, exp_err);
    endtask

    task automatic read_word(input wave_disp_pkg::apb_addr_t addr,
                             input wave_disp_pkg::apb_data_t exp_data, input logic exp_err);
        wave_disp_pkg::apb_data_t d;
        logic                     e;
        apb_access(1'b0, addr, '0, d, e);
        if (e !== exp_err)
            fail_value("pslverr", e, exp_err);
        if (d !== exp_data)
            fail_value("prdata", d, exp_data);
    endtask

    // only the low byte is stored, into the back bank
    task automatic write_sample(input int idx, input wave_disp_pkg::apb_data_t d);
        write_word(wave_disp_pkg::apb_addr_t'(idx * 4), d, 1'b0);
        model_mem[~model_bank][idx] = d[7:0];
    endtask

    task automatic fill_back();
        for (int i = 0; i < `H_ACTIVE; i++) begin
            write_sample(i, $random(seed));
        end
    endtask

    // new samples loaded in one frame, shown from the next
    task automatic swap_and_show();
        @(negedge vs_out);
        fill_back();
        write_word(`APB_CTRL_ADDR, 32'd1, 1'b0);
        model_pending = 1'b1;
        read_word(`APB_CTRL_ADDR, {31'd0, model_pending}, 1'b0);
        wait (!model_pending);
        read_word(`APB_CTRL_ADDR, {31'd0, model_pending}, 1'b0);
        // rest of the old frame, then a whole frame of new samples
        repeat (2) @(posedge vs_out);
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int                        t0;
        int                        idx_list [40];
        wave_disp_pkg::apb_addr_t  bad_addr;
        seed         = 32'hf26f_67a4;
        errors       = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        apb_req      = '0;
        foreach (model_mem[b, i])
            model_mem[b][i] = '0;

        // sync outputs quiet in reset, first frame is a flat trace on row 255
        t0 = errors;
        repeat (8) begin
            @(negedge sys_clk);
            if ({hs_out, vs_out, de_out} != 3'b000)
                fail_value("sync in reset", {hs_out, vs_out, de_out}, 0);
        end
        @(posedge sys_clk);
        rst_n <= 1'b1;
        @(posedge vs_out);
        report_test("reset and first frame", t0);

        // one more frame of raster timing
        t0 = errors;
        @(posedge vs_out);
        report_test("raster timing", t0);

        // random readback, then out of range and unmapped
        t0 = errors;
        @(negedge vs_out);
        for (int n = 0; n < 40; n++) begin
            idx_list[n] = {$random(seed)} % `H_ACTIVE;
            write_sample(idx_list[n], $random(seed));
        end
        for (int n = 0; n < 40; n++) begin
            read_word(wave_disp_pkg::apb_addr_t'(idx_list[n] * 4),
                      {24'd0, model_mem[~model_bank][idx_list[n]]}, 1'b0);
        end
        for (int n = 0; n < 10; n++) begin
            bad_addr = wave_disp_pkg::apb_addr_t'((`H_ACTIVE + {$random(seed)} % 212) * 4);
            write_word(bad_addr, $random(seed), 1'b1);
            read_word(bad_addr, '0, 1'b1);
        end
        read_word(12'h804, '0, 1'b1);
        read_word(12'h003, '0, 1'b1);
        report_test("apb readback and errors", t0);

        t0 = errors;
        swap_and_show();
        report_test("frame aligned swap", t0);

        // second sample set, every pixel compared again
        t0 = errors;
        swap_and_show();
        report_test("pixel colours", t0);

        $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* vga_ctrl.sv */
`timescale 1ns/100ps
`include "wave_disp_defs.svh"

module vga_ctrl (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  wave_disp_pkg::rgb565_t       pix_data,
    output wave_disp_pkg::pix_coord_t    pix_x,
    output wave_disp_pkg::pix_coord_t    pix_y,
    output wave_disp_pkg::video_sync_t   sync,
    output logic                         ram_rd_en,
    output wave_disp_pkg::wave_addr_t    wave_rd_addr,
    output logic                         ram_rd_over,
    output wave_disp_pkg::rgb565_t       rgb
);

    // sync windows, active region starts at count 0
    localparam int HS_START = `H_ACTIVE + `H_FP;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FP;
    localparam int VS_END   = VS_START + `V_SYNC;

    wave_disp_pkg::pix_coord_t  cnt_h;
    wave_disp_pkg::pix_coord_t  cnt_v;
    logic                       h_act;
    logic                       v_act;
    logic                       last_rd;
    wave_disp_pkg::video_sync_t sync_s0;
    wave_disp_pkg::video_sync_t sync_s1;

    //////////////////////////////////////////////////////////////////////
    // stage 0, raster counters
    //////////////////////////////////////////////////////////////////////

    // parked on the last clock of the frame so reset is blank
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_h <= wave_disp_pkg::pix_coord_t'(`H_TOTAL - 1);
            cnt_v <= wave_disp_pkg::pix_coord_t'(`V_TOTAL - 1);
        end else if (cnt_h == wave_disp_pkg::pix_coord_t'(`H_TOTAL - 1)) begin
            cnt_h <= '0;
            // line wrap
            if (cnt_v == wave_disp_pkg::pix_coord_t'(`V_TOTAL - 1))
                cnt_v <= '0;
            else
                cnt_v <= cnt_v + 1'b1;
        end else begin
            cnt_h <= cnt_h + 1'b1;
        end
    end

    // window decode
    assign h_act = (cnt_h < `H_ACTIVE);
    assign v_act = (cnt_v < `V_ACTIVE);

    assign sync_s0.de = h_act && v_act;
    assign sync_s0.hs = (cnt_h >= HS_START) && (cnt_h < HS_END);
    // row based, so vs spans whole lines
    assign sync_s0.vs = (cnt_v >= VS_START) && (cnt_v < VS_END);

    // one read per visible column, address is the column
    assign ram_rd_en    = sync_s0.de;
    assign wave_rd_addr = cnt_h[8:0];

    // read of column 299 on row 255
    assign last_rd = (cnt_h == wave_disp_pkg::pix_coord_t'(`H_ACTIVE - 1))
                     && (cnt_v == wave_disp_pkg::pix_coord_t'(`V_ACTIVE - 1));

    //////////////////////////////////////////////////////////////////////
    // stage 1 and 2, align with ram data and pixel register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_s1     <= '0;
            sync        <= '0;
            ram_rd_over <= 1'b0;
        end else begin
            sync_s1     <= sync_s0;
            sync        <= sync_s1;
            // frame end pulse, one clock after the last read
            ram_rd_over <= last_rd;
        end
    end

    // coordinates ride alongside wave_rd_data
    always_ff @(posedge sys_clk) begin
        pix_x <= cnt_h;
        pix_y <= cnt_v;
    end

    // blank outside the active window
    assign rgb = sync.de ? pix_data : '0;

    // data enable only inside the blanking-free window
    a_de_blank: assert property (@(posedge sys_clk) disable iff (!rst_n)
        sync.de |-> !(sync.hs || sync.vs));

endmodule

/* vga_pic.sv */
`timescale 1ns/100ps
`include "wave_disp_defs.svh"

module vga_pic (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  wave_disp_pkg::pix_coord_t    pix_x,
    input  wave_disp_pkg::pix_coord_t    pix_y,
    input  wave_disp_pkg::sample_t       wave_rd_data,
    output wave_disp_pkg::rgb565_t       pix_data
);

    wave_disp_pkg::pix_coord_t trace_row;
    logic                      on_trace;
    logic                      on_grid_x;
    logic                      on_grid_y;
    wave_disp_pkg::rgb565_t    pix_next;

    //////////////////////////////////////////////////////////////////////
    // hit tests on the stage 1 coordinates
    //////////////////////////////////////////////////////////////////////

    // level 0 sits on the bottom row
    assign trace_row = {4'd0, 8'd255 - wave_rd_data};
    assign on_trace  = (pix_y == trace_row);

    // vertical grid lines every 30 columns
    assign on_grid_x = ((pix_x % `GRID_X) == 0);
    // horizontal grid lines every 32 rows
    assign on_grid_y = ((pix_y % `GRID_Y) == 0);

    // trace over grid over background
    always_comb begin
        if (on_trace)
            pix_next = `COL_TRACE;
        else if (on_grid_x || on_grid_y)
            pix_next = `COL_GRID;
        else
            pix_next = `COL_BG;
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2 pixel register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n)
            pix_data <= `COL_BG;
        else
            pix_data <= pix_next;
    end

endmodule

/* wave_disp_defs.svh */
`ifndef WAVE_DISP_DEFS_SVH
`define WAVE_DISP_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// video mode, one column per sample and one row per level
//////////////////////////////////////////////////////////////////////

// horizontal, in pixel clocks
`define H_ACTIVE      300
`define H_FP          8
`define H_SYNC        16
`define H_BP          16
// 340 clocks per line
`define H_TOTAL       (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// vertical, in lines
`define V_ACTIVE      256
`define V_FP          2
`define V_SYNC        2
`define V_BP          4
// 264 lines per frame
`define V_TOTAL       (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// graticule spacing
`define GRID_X        30
`define GRID_Y        32

// rgb565 colours, yellow trace on grey grid over black
`define COL_TRACE     16'hffe0
`define COL_GRID      16'h8410
`define COL_BG        16'h0000

// apb map, samples at 4n from 0, control above them
`define APB_CTRL_ADDR 12'h800

`endif

/* wave_disp_pkg.sv */
package wave_disp_pkg;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    // raster column or row
    typedef logic [11:0] pix_coord_t;
    // one stored sample, 0 is the bottom row
    typedef logic [7:0]  sample_t;
    // sample index 0..299
    typedef logic [8:0]  wave_addr_t;
    // r in 15:11, g in 10:5, b in 4:0
    typedef logic [15:0] rgb565_t;
    // apb byte address and data word
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    // sync bits of one pixel, active high
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
    } video_sync_t;

    // host side of apb
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // slave side of apb
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage

/* wave_ram.sv */
`timescale 1ns/100ps
`include "wave_disp_defs.svh"

module wave_ram (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  wave_disp_pkg::apb_req_t      apb_req,
    output wave_disp_pkg::apb_rsp_t      apb_rsp,
    input  logic                         ram_rd_en,
    input  wave_disp_pkg::wave_addr_t    wave_rd_addr,
    input  logic                         ram_rd_over,
    output wave_disp_pkg::sample_t       wave_rd_data
);

    // two banks, bank_sel names the one on screen
    wave_disp_pkg::sample_t    mem [0:1][0:`H_ACTIVE-1];
    logic                      bank_sel;
    logic                      swap_pending;

    logic                      setup;
    logic                      access;
    logic                      sample_hit;
    logic                      ctrl_hit;
    wave_disp_pkg::wave_addr_t idx;
    wave_disp_pkg::apb_data_t  prdata_q;
    logic                      pslverr_q;

    //////////////////////////////////////////////////////////////////////
    // apb decode
    //////////////////////////////////////////////////////////////////////

    assign setup  = apb_req.psel && !apb_req.penable;
    assign access = apb_req.psel && apb_req.penable;

    // word index from byte address
    assign idx = apb_req.paddr[10:2];
    // aligned word below the control page and inside the store
    assign sample_hit = !apb_req.paddr[11] && (apb_req.paddr[1:0] == 2'b00)
                        && (idx < `H_ACTIVE);
    assign ctrl_hit   = (apb_req.paddr == `APB_CTRL_ADDR);

    // zero wait states, response prepared in setup
    assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else if (setup) begin
            // readback is always from the back bank
            if (sample_hit)
                prdata_q <= {24'd0, mem[~bank_sel][idx]};
            else if (ctrl_hit)
                prdata_q <= {31'd0, swap_pending};
            else
                prdata_q <= '0;
            pslverr_q <= !(sample_hit || ctrl_hit);
        end else if (access) begin
            // error only lasts for the access cycle
            pslverr_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage, swap and display read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `H_ACTIVE; i++) begin
                    mem[b][i] <= '0;
                end
            end
            bank_sel     <= 1'b0;
            swap_pending <= 1'b0;
            wave_rd_data <= '0;
        end else begin
            // swap once the last pixel of the frame has been read
            if (ram_rd_over && swap_pending) begin
                bank_sel     <= ~bank_sel;
                swap_pending <= 1'b0;
            end
            // host writes land in the back bank
            if (access && apb_req.pwrite && sample_hit)
                mem[~bank_sel][idx] <= apb_req.pwdata[7:0];
            // a request in the swap cycle waits for the next frame
            if (access && apb_req.pwrite && ctrl_hit && apb_req.pwdata[0])
                swap_pending <= 1'b1;
            // display port, one clock latency
            if (ram_rd_en)
                wave_rd_data <= mem[bank_sel][wave_rd_addr];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // raster never reads past the stored samples
    a_rd_addr_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
        ram_rd_en |-> (wave_rd_addr < `H_ACTIVE));

    // host keeps apb phase order
    a_penable_psel: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(apb_req.penable) |-> apb_req.psel);

endmodule
